// File: design/vgaGfx_config.svh
// VGA graphics configuration with 640x480 timing, tile grid and host register map
`ifndef VGAGFX_CONFIG_SVH
`define VGAGFX_CONFIG_SVH

// horizontal timing in pixel clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// background made of 16x16 pixel tiles
`define TILE_COLS 40
`define TILE_ROWS 30
`define TILE_DEPTH (`TILE_COLS * `TILE_ROWS)
`define BAR_WIDTH 80

`define AXI_ADDR_W 16
`define REG_SCREEN 16'h0000
`define REG_PAL0 16'h0004
`define REG_PAL1 16'h0008
`define REG_SPRITE 16'h000C   // sprite x in bits 6:0, y in bits 14:8
`define REG_FRAMES 16'h0010   // read only
`define TILE_BASE 16'h1000    // one word per tile

`endif

// File: design/vgaGfxPkg.sv
// shared types of the VGA graphics subsystem
`default_nettype none

package vgaGfxPkg;

    typedef enum logic [1:0] {
        scrWelcome = 2'd0,
        scrBars    = 2'd1,
        scrGame    = 2'd2,
        scrBlank   = 2'd3
    } screenT;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgbT;

    // beam position plus its raw syncs
    typedef struct packed {
        logic [9:0] x;
        logic [8:0] y;
        logic       active;
        logic       hSync;   // active low
        logic       vSync;   // active low
    } pixPosT;

    // sprite origin in pixels is four times each field
    typedef struct packed {
        screenT     screen;
        rgbT        pal0;
        rgbT        pal1;
        logic [6:0] spriteX;
        logic [6:0] spriteY;
    } videoRegsT;

    typedef struct packed {
        logic        req;    // held until granted
        logic        we;
        logic [10:0] idx;
        logic [1:0]  data;
    } tileReqT;

endpackage

`default_nettype wire

// File: design/vgaTiming.sv
// VGA raster timing with 640x480 counters, syncs, active window and end-of-frame pulse
`timescale 1ns/100ps
`default_nettype none
`include "vgaGfx_config.svh"

module vgaTiming import vgaGfxPkg::*; (
    input  logic   clk,
    input  logic   arstN,
    output pixPosT pos,
    output logic   frameEnd
);

    localparam logic [9:0] H_LAST   = 10'(`H_TOTAL - 1);
    localparam logic [9:0] V_LAST   = 10'(`V_TOTAL - 1);
    localparam logic [9:0] HS_START = 10'(`H_ACTIVE + `H_FRONT);
    localparam logic [9:0] HS_END   = 10'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam logic [9:0] VS_START = 10'(`V_ACTIVE + `V_FRONT);
    localparam logic [9:0] VS_END   = 10'(`V_ACTIVE + `V_FRONT + `V_SYNC);

    logic [9:0] hCnt;
    logic [9:0] vCnt;   // reaches 524, wider than pos.y

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            hCnt <= '0;
            vCnt <= '0;
        end else if (hCnt == H_LAST) begin
            hCnt <= '0;
            vCnt <= (vCnt == V_LAST) ? 10'd0 : vCnt + 10'd1;
        end else begin
            hCnt <= hCnt + 10'd1;
        end
    end

    always_comb begin
        pos.x      = hCnt;
        pos.y      = vCnt[8:0];
        pos.active = (hCnt < 10'(`H_ACTIVE)) && (vCnt < 10'(`V_ACTIVE));
        pos.hSync  = !((hCnt >= HS_START) && (hCnt < HS_END));
        pos.vSync  = !((vCnt >= VS_START) && (vCnt < VS_END));
    end

    // last clock of the last line
    assign frameEnd = (hCnt == H_LAST) && (vCnt == V_LAST);

    frameEndSingle: assert property (
        @(posedge clk) disable iff (!arstN) frameEnd |=> !frameEnd
    );

endmodule

`default_nettype wire

// File: design/gfxRegs.sv
// AXI4-Lite register block with frame-latched display registers and tile memory access
`timescale 1ns/100ps
`default_nettype none
`include "vgaGfx_config.svh"

module gfxRegs import vgaGfxPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    input  logic                   frameEnd,
    output videoRegsT              live,
    output tileReqT                tileReq,
    input  logic                   tileGrant,
    input  logic [1:0]             tileRdData
);

    typedef enum logic [2:0] {sIdle, sExec, sTile, sTileRd, sResp} stateT;

    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam videoRegsT REGS_RESET = '{screen: scrWelcome, pal0: 12'h00F, pal1: 12'hF80,
                                         spriteX: 7'd0, spriteY: 7'd0};

    stateT                  state;
    logic                   awHeld;
    logic                   wHeld;
    logic                   isWr;
    logic [`AXI_ADDR_W-1:0] addrQ;
    logic [31:0]            wdataQ;
    logic [31:0]            rdataQ;
    logic [31:0]            regRead;
    logic [1:0]             respQ;
    logic [15:0]            frames;
    videoRegsT              pending;   // host side copy
    logic [`AXI_ADDR_W-1:0] tileOff;
    logic                   tileHit;

    assign awready = (state == sIdle) && !awHeld;
    assign wready  = (state == sIdle) && !wHeld;
    assign arready = (state == sIdle) && !awHeld && !wHeld && !awvalid && !wvalid; // writes first
    assign bvalid  = (state == sResp) && isWr;
    assign rvalid  = (state == sResp) && !isWr;
    assign bresp   = respQ;
    assign rresp   = respQ;
    assign rdata   = rdataQ;

    assign tileOff = addrQ - `TILE_BASE;
    assign tileHit = (addrQ >= `TILE_BASE) && (addrQ < `TILE_BASE + 16'(4 * `TILE_DEPTH));
    assign tileReq = '{req: state == sTile, we: isWr, idx: tileOff[12:2], data: wdataQ[1:0]};

    always_comb begin
        case (addrQ)
            `REG_SCREEN: regRead = {30'd0, pending.screen};
            `REG_PAL0:   regRead = {20'd0, pending.pal0};
            `REG_PAL1:   regRead = {20'd0, pending.pal1};
            `REG_SPRITE: regRead = {17'd0, pending.spriteY, 1'b0, pending.spriteX};
            `REG_FRAMES: regRead = {16'd0, frames};
            default:     regRead = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state   <= sIdle;
            awHeld  <= 1'b0;
            wHeld   <= 1'b0;
            isWr    <= 1'b0;
            respQ   <= OKAY;
            pending <= REGS_RESET;
        end else begin
            case (state)
                sIdle: begin
                    if (awvalid && awready)
                        awHeld <= 1'b1;
                    if (wvalid && wready)
                        wHeld <= 1'b1;
                    if (awHeld && wHeld) begin   // both halves of the write collected
                        awHeld <= 1'b0;
                        wHeld  <= 1'b0;
                        isWr   <= 1'b1;
                        state  <= sExec;
                    end else if (arvalid && arready) begin
                        isWr  <= 1'b0;
                        state <= sExec;
                    end
                end
                sExec: begin
                    respQ <= OKAY;
                    state <= tileHit ? sTile : sResp;
                    if (!tileHit) begin
                        case (addrQ)
                            `REG_SCREEN: if (isWr) pending.screen <= screenT'(wdataQ[1:0]);
                            `REG_PAL0:   if (isWr) pending.pal0 <= wdataQ[11:0];
                            `REG_PAL1:   if (isWr) pending.pal1 <= wdataQ[11:0];
                            `REG_SPRITE: begin
                                if (isWr) begin
                                    pending.spriteX <= wdataQ[6:0];
                                    pending.spriteY <= wdataQ[14:8];
                                end
                            end
                            `REG_FRAMES: respQ <= OKAY;   // writes ignored
                            default:     respQ <= SLVERR;
                        endcase
                    end
                end
                sTile:   if (tileGrant) state <= isWr ? sResp : sTileRd;
                sTileRd: state <= sResp;
                sResp:   if ((isWr && bready) || (!isWr && rready)) state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (awvalid && awready)
            addrQ <= awaddr;
        else if (arvalid && arready)
            addrQ <= araddr;
        if (wvalid && wready)
            wdataQ <= wdata;
        if (state == sExec)
            rdataQ <= regRead;
        else if (state == sTileRd)
            rdataQ <= {30'd0, tileRdData};   // data one cycle after grant
    end

    // display copy only moves at the frame boundary
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            frames <= '0;
            live   <= REGS_RESET;
        end else if (frameEnd) begin
            frames <= frames + 16'd1;
            live   <= pending;
        end
    end

    // master keeps a read request up until it is taken
    arHolds: assert property (
        @(posedge clk) disable iff (!arstN) arvalid && !arready |=> arvalid
    );

endmodule

`default_nettype wire

// File: design/tileMem.sv
// tile map RAM shared by renderer and host through a fixed-priority arbiter
`timescale 1ns/100ps
`default_nettype none
`include "vgaGfx_config.svh"

module tileMem import vgaGfxPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic [10:0] rendIdx,
    input  logic        rendReq,
    output logic [1:0]  rendData,
    input  tileReqT     hostReq,
    output logic        hostGrant,
    output logic [1:0]  hostData
);

    logic [1:0]  mem [`TILE_DEPTH];
    logic        sweeping;   // clearing after reset
    logic        sweepQ;
    logic [10:0] sweepIdx;
    logic [10:0] addr;
    logic        wrEn;
    logic [1:0]  wrData;
    logic [1:0]  rdQ;

    // renderer always wins, host only gets idle cycles
    assign hostGrant = hostReq.req && !rendReq && !sweeping;

    always_comb begin
        if (sweeping) begin
            addr = sweepIdx;
            wrEn = 1'b1;
        end else if (rendReq) begin
            addr = rendIdx;
            wrEn = 1'b0;
        end else begin
            addr = hostReq.idx;
            wrEn = hostGrant && hostReq.we;
        end
    end

    assign wrData = sweeping ? 2'd0 : hostReq.data;

    // single port, read one cycle later
    always_ff @(posedge clk) begin
        if (wrEn)
            mem[addr] <= wrData;
        rdQ <= mem[addr];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sweeping <= 1'b1;
            sweepQ   <= 1'b1;
            sweepIdx <= '0;
        end else begin
            sweepQ <= sweeping;
            if (sweeping) begin
                sweepIdx <= sweepIdx + 11'd1;
                if (sweepIdx == 11'(`TILE_DEPTH - 1))
                    sweeping <= 1'b0;
            end
        end
    end

    assign rendData = sweepQ ? 2'd0 : rdQ;   // code 0 until the sweep is done
    assign hostData = rdQ;

    // requester must keep a stalled request steady
    hostHolds: assert property (
        @(posedge clk) disable iff (!arstN)
        hostReq.req && !hostGrant |=> hostReq.req && $stable(hostReq)
    );

endmodule

`default_nettype wire

// File: design/pixelRenderer.sv
// two-stage pixel pipeline from beam position and display registers to RGB and syncs
`timescale 1ns/100ps
`default_nettype none
`include "vgaGfx_config.svh"

module pixelRenderer import vgaGfxPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  pixPosT      pos,
    input  videoRegsT   regs,
    output logic [10:0] tileIdx,
    output logic        tileReq,
    input  logic [1:0]  tileCode,
    output rgbT         rgb,
    output logic        hSync,
    output logic        vSync
);

    localparam rgbT BLACK = 12'h000;
    localparam rgbT WHITE = 12'hFFF;
    localparam pixPosT POS_IDLE = '{x: 10'd0, y: 9'd0, active: 1'b0, hSync: 1'b1, vSync: 1'b1};

    pixPosT     s1Pos;
    logic [9:0] sprX;   // sprite origin in pixels
    logic [9:0] sprY;
    logic [9:0] s1Y;
    logic       inSprite;
    logic [2:0] bar;
    rgbT        tileRgb;
    rgbT        pixRgb;

    function automatic logic [2:0] barOf(input logic [9:0] x);
        logic [2:0] k;
        k = 3'd0;
        for (int i = 1; i < 8; i++) begin
            if (x >= 10'(i * `BAR_WIDTH))
                k = 3'(i);
        end
        return k;
    endfunction

    // stage 1 fetches the tile under the beam
    assign tileIdx = 11'(pos.y[8:4]) * 11'(`TILE_COLS) + 11'(pos.x[9:4]);
    assign tileReq = pos.active;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            s1Pos <= POS_IDLE;
        else
            s1Pos <= pos;
    end

    // stage 2, tileCode now lines up with s1Pos
    assign sprX     = {1'b0, regs.spriteX, 2'b00};
    assign sprY     = {1'b0, regs.spriteY, 2'b00};
    assign s1Y      = {1'b0, s1Pos.y};
    assign inSprite = (s1Pos.x >= sprX) && (s1Pos.x < sprX + 10'd8) &&
                      (s1Y >= sprY) && (s1Y < sprY + 10'd8);
    assign bar      = barOf(s1Pos.x);

    always_comb begin
        case (tileCode)
            2'd0:    tileRgb = regs.pal0;
            2'd1:    tileRgb = regs.pal1;
            2'd2:    tileRgb = BLACK;
            default: tileRgb = WHITE;
        endcase
    end

    always_comb begin
        pixRgb = BLACK;   // blanking stays dark
        if (s1Pos.active) begin
            case (regs.screen)
                scrWelcome: pixRgb = regs.pal0;
                scrBars:    pixRgb = '{r: {4{bar[2]}}, g: {4{bar[1]}}, b: {4{bar[0]}}};
                scrGame:    pixRgb = inSprite ? (WHITE ^ tileRgb) : tileRgb;
                default:    pixRgb = BLACK;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rgb   <= BLACK;
            hSync <= 1'b1;
            vSync <= 1'b1;
        end else begin
            rgb   <= pixRgb;
            hSync <= s1Pos.hSync;   // syncs ride along with the colour
            vSync <= s1Pos.vSync;
        end
    end

endmodule

`default_nettype wire

// File: design/vgaGraphics.sv
// VGA graphics subsystem top joining timing, registers, tile memory and renderer
`timescale 1ns/100ps
`default_nettype none
`include "vgaGfx_config.svh"

module vgaGraphics import vgaGfxPkg::*; (
    input  logic                   clk,
    input  logic                   arstN,
    input  logic [`AXI_ADDR_W-1:0] awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [`AXI_ADDR_W-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output logic                   hSync,
    output logic                   vSync,
    output logic [3:0]             vgaR,
    output logic [3:0]             vgaG,
    output logic [3:0]             vgaB,
    output logic                   screenEnd
);

    pixPosT      pos;
    videoRegsT   liveRegs;
    tileReqT     hostReq;
    logic        hostGrant;
    logic [1:0]  hostData;
    logic [10:0] rendIdx;
    logic        rendReq;
    logic [1:0]  rendData;
    rgbT         rgb;

    vgaTiming vgaTiming_inst (.clk, .arstN, .pos, .frameEnd(screenEnd));

    gfxRegs gfxRegs_inst (
        .clk, .arstN,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready,
        .frameEnd(screenEnd), .live(liveRegs),
        .tileReq(hostReq), .tileGrant(hostGrant), .tileRdData(hostData)
    );

    tileMem tileMem_inst (
        .clk, .arstN, .rendIdx, .rendReq, .rendData,
        .hostReq, .hostGrant, .hostData
    );

    pixelRenderer pixelRenderer_inst (
        .clk, .arstN, .pos, .regs(liveRegs),
        .tileIdx(rendIdx), .tileReq(rendReq), .tileCode(rendData),
        .rgb, .hSync, .vSync
    );

    assign vgaR = rgb.r;
    assign vgaG = rgb.g;
    assign vgaB = rgb.b;

endmodule

`default_nettype wire

// File: test/vgaGraphicsTb.sv
// testbench for the VGA graphics subsystem with an AXI4-Lite host model and a pixel scan checker
`timescale 1ns/100ps
`default_nettype none
`include "vgaGfx_config.svh"

module vgaGraphicsTb import vgaGfxPkg::*; ();

    localparam int TIMEOUT = 4000;   // cycles per AXI phase
    localparam int FRAME_TIMEOUT = 2 * `H_TOTAL * `V_TOTAL;
    localparam logic [1:0] OKAY = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;
    localparam videoRegsT REGS_RESET = '{screen: scrWelcome, pal0: 12'h00F, pal1: 12'hF80,
                                         spriteX: 7'd0, spriteY: 7'd0};

    logic        clk;
    logic        arstN;
    logic [15:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        hSync;
    logic        vSync;
    logic [3:0]  vgaR;
    logic [3:0]  vgaG;
    logic [3:0]  vgaB;
    logic        screenEnd;

    // host view of the registers and the tile map
    videoRegsT   pendM;
    videoRegsT   liveM;
    logic [1:0]  tileM [`TILE_DEPTH];
    logic [31:0] rngState;
    int          hPos;   // beam position of the RGB outputs
    int          vPos;
    bit          locked;
    logic        prevH;
    logic        prevV;
    int          frameCnt;
    longint      pixChecks;

    vgaGraphics vgaGraphics_inst (.*);

    always #5 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
            abortRun("value mismatch");
        end
    endtask

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // expected colour of one active pixel
    function automatic rgbT refPixel(input videoRegsT r, input int x, input int y);
        rgbT        tile;
        logic [2:0] bar;
        bit         inSpr;
        case (tileM[(y / 16) * `TILE_COLS + x / 16])
            2'd0:    tile = r.pal0;
            2'd1:    tile = r.pal1;
            2'd2:    tile = 12'h000;
            default: tile = 12'hFFF;
        endcase
        bar = 3'(x / `BAR_WIDTH);
        inSpr = (x >= 4 * r.spriteX) && (x < 4 * r.spriteX + 8) &&
                (y >= 4 * r.spriteY) && (y < 4 * r.spriteY + 8);
        case (r.screen)
            scrWelcome: return r.pal0;
            scrBars:    return {{4{bar[2]}}, {4{bar[1]}}, {4{bar[0]}}};
            scrGame:    return inSpr ? (tile ^ 12'hFFF) : tile;
            default:    return 12'h000;
        endcase
    endfunction

    task automatic axiWrite(input logic [15:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int t;
        bit awDone;
        bit wDone;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        awDone = 1'b0;
        wDone  = 1'b0;
        t = 0;
        while (!(awDone && wDone)) begin
            @(negedge clk);
            awDone = awDone || awready;
            wDone  = wDone || wready;
            @(posedge clk);
            if (awDone)
                awvalid <= 1'b0;
            if (wDone)
                wvalid <= 1'b0;
            t++;
            if (t > TIMEOUT)
                abortRun("AXI write address or data handshake timed out");
        end
        t = 0;
        @(negedge clk);
        while (!bvalid) begin
            t++;
            if (t > TIMEOUT)
                abortRun("timed out waiting for BVALID");
            @(negedge clk);
        end
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [15:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int t;
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        t = 0;
        @(negedge clk);
        while (!arready) begin
            t++;
            if (t > TIMEOUT)
                abortRun("AXI read address handshake timed out");
            @(negedge clk);
        end
        @(posedge clk);
        arvalid <= 1'b0;
        t = 0;
        @(negedge clk);
        while (!rvalid) begin
            t++;
            if (t > TIMEOUT)
                abortRun("timed out waiting for RVALID");
            @(negedge clk);
        end
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic writeOk(input logic [15:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axiWrite(addr, data, resp);
        check("bresp", resp, OKAY);
    endtask

    task automatic readCheck(input logic [15:0] addr, input logic [31:0] exp, input string name);
        logic [31:0] data;
        logic [1:0]  resp;
        axiRead(addr, data, resp);
        check("rresp", resp, OKAY);
        check(name, data, exp);
    endtask

    task automatic waitFrameEnd();
        int t;
        t = 0;
        @(negedge clk);
        while (!screenEnd) begin
            t++;
            if (t > FRAME_TIMEOUT)
                abortRun("timed out waiting for screenEnd");
            @(negedge clk);
        end
    endtask

    task automatic waitLine(input int line);
        int t;
        t = 0;
        @(negedge clk);
        while (!(locked && vPos == line)) begin
            t++;
            if (t > FRAME_TIMEOUT)
                abortRun("timed out waiting for a video line");
            @(negedge clk);
        end
    endtask

    // scan checker, outputs are stable at the falling edge
    always @(negedge clk) begin
        rgbT  expRgb;
        logic act;
        if (arstN) begin
            if (locked) begin
                if (hPos == `H_TOTAL - 1) begin
                    hPos = 0;
                    vPos = (vPos == `V_TOTAL - 1) ? 0 : vPos + 1;
                end else begin
                    hPos = hPos + 1;
                end
            end else if (prevV && !vSync) begin
                locked = 1'b1;   // first vSync fall fixes the line count
                hPos = 0;
                vPos = `V_ACTIVE + `V_FRONT;
            end
            if (locked) begin
                if (prevH && !hSync)
                    check("hSync fall x", hPos, `H_ACTIVE + `H_FRONT);
                act = (hPos < `H_ACTIVE) && (vPos < `V_ACTIVE);
                expRgb = act ? refPixel(liveM, hPos, vPos) : 12'h000;
                check("{vgaR,vgaG,vgaB}", {vgaR, vgaG, vgaB}, expRgb);
                check("hSync", hSync, !(hPos >= `H_ACTIVE + `H_FRONT &&
                                        hPos < `H_ACTIVE + `H_FRONT + `H_SYNC));
                check("vSync", vSync, !(vPos >= `V_ACTIVE + `V_FRONT &&
                                        vPos < `V_ACTIVE + `V_FRONT + `V_SYNC));
                // screenEnd is not delayed, so it leads the RGB position by 2
                check("screenEnd", screenEnd, (hPos == `H_TOTAL - 3) && (vPos == `V_TOTAL - 1));
                if (act)
                    pixChecks++;
            end
            if (screenEnd) begin
                frameCnt++;
                liveM = pendM;
            end
            prevH = hSync;
            prevV = vSync;
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] r;
        logic [31:0] lastFrames;
        logic [1:0]  resp;
        logic [6:0]  sx;
        logic [6:0]  sy;
        int          idx;
        int          lastIdx;
        clk = 1'b0;
        arstN = 1'b0;
        awaddr = '0;
        awvalid = 1'b0;
        wdata = '0;
        wvalid = 1'b0;
        bready = 1'b0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rngState = 32'h601f_925e;
        pendM = REGS_RESET;
        liveM = REGS_RESET;
        foreach (tileM[i])
            tileM[i] = 2'd0;
        locked = 1'b0;
        prevH = 1'b1;
        prevV = 1'b1;
        hPos = 0;
        vPos = 0;
        frameCnt = 0;
        pixChecks = 0;

        @(posedge clk);
        @(negedge clk);   // still in reset
        check("awready", awready, 1'b1);
        check("wready", wready, 1'b1);
        check("arready", arready, 1'b1);
        check("bvalid", bvalid, 1'b0);
        check("rvalid", rvalid, 1'b0);
        check("{vgaR,vgaG,vgaB}", {vgaR, vgaG, vgaB}, 12'h000);
        check("hSync", hSync, 1'b1);
        check("vSync", vSync, 1'b1);
        check("screenEnd", screenEnd, 1'b0);
        @(posedge clk);
        arstN <= 1'b1;

        // welcome screen, frame counter and reset readback
        waitFrameEnd();
        axiRead(`REG_FRAMES, rd, resp);
        check("rresp", resp, OKAY);
        check("REG_FRAMES", rd, frameCnt);
        lastFrames = rd;
        readCheck(`REG_SCREEN, 32'd0, "REG_SCREEN");
        readCheck(`REG_PAL0, 32'h00F, "REG_PAL0");
        readCheck(`REG_PAL1, 32'hF80, "REG_PAL1");
        waitFrameEnd();
        axiRead(`REG_FRAMES, rd, resp);
        check("rresp", resp, OKAY);
        check("REG_FRAMES", rd, frameCnt);
        check("REG_FRAMES step", rd, lastFrames + 32'd1);

        // palette write mid-frame shows only from the next frame
        waitLine(240);
        r = nextRand();
        writeOk(`REG_PAL0, {20'd0, r[11:0]});
        pendM.pal0 = r[11:0];
        readCheck(`REG_PAL0, {20'd0, r[11:0]}, "REG_PAL0");
        waitFrameEnd();
        waitFrameEnd();

        writeOk(`REG_SCREEN, 32'd1);
        pendM.screen = scrBars;
        waitFrameEnd();
        waitFrameEnd();

        // game screen with random tiles and sprite
        lastIdx = 0;
        repeat (48) begin
            idx = int'(nextRand() % `TILE_DEPTH);
            r = nextRand();
            writeOk(16'(`TILE_BASE + 4 * idx), {30'd0, r[1:0]});
            tileM[idx] = r[1:0];
            lastIdx = idx;
        end
        r = nextRand();
        sx = r[6:0];
        sy = 7'(r[14:8] % 118);   // keep the sprite on screen
        writeOk(`REG_SPRITE, {17'd0, sy, 1'b0, sx});
        writeOk(`REG_PAL1, {20'd0, r[27:16]});
        writeOk(`REG_SCREEN, 32'd2);
        pendM.spriteX = sx;
        pendM.spriteY = sy;
        pendM.pal1 = r[27:16];
        pendM.screen = scrGame;
        waitFrameEnd();
        waitLine(100);
        // same code again, so the picture stays put while the host stalls
        writeOk(16'(`TILE_BASE + 4 * lastIdx), {30'd0, tileM[lastIdx]});
        readCheck(16'(`TILE_BASE + 4 * lastIdx), {30'd0, tileM[lastIdx]}, "tile readback");
        idx = int'(nextRand() % `TILE_DEPTH);
        readCheck(16'(`TILE_BASE + 4 * idx), {30'd0, tileM[idx]}, "tile readback");
        waitFrameEnd();

        // unmapped addresses
        axiWrite(16'h0020, 32'hFFF, resp);
        check("bresp", resp, SLVERR);
        axiWrite(16'(`TILE_BASE + 4 * `TILE_DEPTH), 32'd3, resp);
        check("bresp", resp, SLVERR);
        axiRead(16'h0800, rd, resp);
        check("rresp", resp, SLVERR);
        readCheck(`REG_PAL0, {20'd0, pendM.pal0}, "REG_PAL0");
        waitFrameEnd();

        if (pixChecks < 7 * `H_ACTIVE * `V_ACTIVE) begin
            abortRun("scanner compared fewer active pixels than expected");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: vgaGraphics.f
+incdir+design
design/vgaGfxPkg.sv
design/vgaTiming.sv
design/gfxRegs.sv
design/tileMem.sv
design/pixelRenderer.sv
design/vgaGraphics.sv
test/vgaGraphicsTb.sv
